/* npc_pkg.sv */
package npc_pkg;

    // fetch works on word addresses, so pc+1 is the next sequential instruction
    localparam int ADDR_WIDTH = 30;

    // history length and table index share one width
    localparam int GH_WIDTH = 6;
    localparam int TABLE_LEN = 1 << GH_WIDTH;

    localparam int STACK_LEN = 8;
    localparam int SP_WIDTH = $clog2(STACK_LEN);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [GH_WIDTH-1:0] idx_t;

    // kind of control transfer, decoded upstream of the predictor
    // value 7 is unused and is handled like NOT_JUMP everywhere
    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        JUMP          = 3'd2,
        CALL          = 3'd3,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        OTHER_JUMP    = 3'd6
    } jump_kind_e;

endpackage

/* gh_hasher.sv */
module gh_hasher (
    input  logic                clk,
    input  logic                rstn,
    input  npc_pkg::addr_t      pc,
    input  npc_pkg::jump_kind_e kind_ex,
    input  logic                taken_ex,
    output npc_pkg::idx_t       pc_gh_hashed
);
    import npc_pkg::*;

    idx_t ghr;
    logic resolved_jump;

    // only real control transfers leave a mark in the history
    always_comb begin
        case (kind_ex)
            DIRECT_JUMP,
            JUMP,
            CALL,
            RET,
            INDIRECT_JUMP,
            OTHER_JUMP: resolved_jump = 1'b1;
            default:    resolved_jump = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ghr <= '0;
        end else if (resolved_jump) begin
            ghr <= {ghr[GH_WIDTH-2:0], taken_ex}; // newest outcome enters at bit 0
        end
    end

    // the execute stage carries this index down the pipe for its update
    assign pc_gh_hashed = pc[GH_WIDTH-1:0] ^ ghr;

endmodule

/* btb.sv */
module btb (
    input  logic           clk,
    input  logic           rstn,
    // lookup port
    input  npc_pkg::idx_t  hashed_pc,
    output npc_pkg::addr_t npc_pdc,
    output logic           hit,
    // update port
    input  npc_pkg::idx_t  hashed_pc_update,
    input  npc_pkg::addr_t npc_real,
    input  logic           update_en
);
    import npc_pkg::*;

    addr_t                target [TABLE_LEN];
    logic [TABLE_LEN-1:0] valid;

    // the target array is only trusted once its valid bit is set
    always_ff @(posedge clk) begin
        if (update_en) begin
            target[hashed_pc_update] <= npc_real;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (update_en) begin
            valid[hashed_pc_update] <= 1'b1;
        end
    end

    // combinational read so the prediction lands in the fetch cycle
    assign npc_pdc = target[hashed_pc];
    assign hit     = valid[hashed_pc];

endmodule

/* ras.sv */
module ras (
    input  logic           clk,
    input  logic           rstn,
    input  logic           is_call_ex,
    input  npc_pkg::addr_t ret_pc_ex,
    input  logic           is_ret_ex,
    output npc_pkg::addr_t ret_pc_pdc,
    output logic           empty
);
    import npc_pkg::*;

    localparam logic [SP_WIDTH:0] FULL_CNT = (SP_WIDTH+1)'(STACK_LEN);

    addr_t               stack [STACK_LEN];
    logic [SP_WIDTH-1:0] top;      // index of the current top entry
    logic [SP_WIDTH-1:0] next_top;
    logic [SP_WIDTH-1:0] prev_top;
    logic [SP_WIDTH:0]   count;
    logic                push;
    logic                pop;

    // pointers wrap around the ring, so a push when full replaces the oldest entry
    assign next_top = top + 1'b1;
    assign prev_top = top - 1'b1;

    assign push = is_call_ex;
    assign pop  = is_ret_ex && (count != '0); // popping an empty stack does nothing

    always_ff @(posedge clk) begin
        if (push) begin
            stack[next_top] <= ret_pc_ex;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            top   <= '0;
            count <= '0;
        end else if (push) begin
            top <= next_top;
            if (count != FULL_CNT) begin
                count <= count + 1'b1;
            end
        end else if (pop) begin
            top   <= prev_top;
            count <= count - 1'b1;
        end
    end

    // the selector ignores the top entry while the stack is empty
    assign ret_pc_pdc = stack[top];
    assign empty      = (count == '0);

endmodule

/* cpht.sv */
module cpht (
    input  logic          clk,
    input  logic          rstn,
    input  npc_pkg::idx_t hashed_pc,
    output logic          choice_pdc,
    input  npc_pkg::idx_t hashed_pc_update,
    input  logic          choice_real,
    input  logic          update_en
);
    import npc_pkg::*;

    // 00 and 01 lean to the btb, 10 and 11 lean to the stack
    logic [1:0] ctr [TABLE_LEN];
    logic [1:0] cur;

    assign cur = ctr[hashed_pc_update];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < TABLE_LEN; i++) begin
                ctr[i] <= 2'b01; // weakly btb
            end
        end else if (update_en) begin
            if (choice_real) begin
                if (cur != 2'b11) begin
                    ctr[hashed_pc_update] <= cur + 2'd1;
                end
            end else if (cur != 2'b00) begin
                ctr[hashed_pc_update] <= cur - 2'd1;
            end
        end
    end

    assign choice_pdc = ctr[hashed_pc][1];

endmodule

/* npc_predictor.sv */
module npc_predictor (
    input  logic                clk,
    input  logic                rstn,
    // fetch side
    input  npc_pkg::idx_t       pc_gh_hashed,
    input  npc_pkg::addr_t      pc,
    input  npc_pkg::jump_kind_e kind_pdc,
    input  logic                taken_pdc,
    // execute side
    input  npc_pkg::idx_t       pc_ex_gh_hashed,
    input  npc_pkg::addr_t      pc_ex,
    input  npc_pkg::addr_t      npc_ex,
    input  npc_pkg::jump_kind_e kind_ex,
    input  logic                choice_real,
    // prediction
    output npc_pkg::addr_t      npc_pdc,
    output logic                choice_btb_ras // 0 picks btb, 1 picks ras
);
    import npc_pkg::*;

    addr_t npc_btb;
    addr_t npc_ras;
    addr_t pc_seq;
    addr_t btb_pick;
    addr_t ret_pc_ex;
    logic  btb_hit;
    logic  ras_empty;
    logic  btb_upd;

    always_comb begin
        case (kind_ex)
            DIRECT_JUMP, JUMP, CALL, RET, INDIRECT_JUMP, OTHER_JUMP: btb_upd = 1'b1;
            default: btb_upd = 1'b0;
        endcase
    end

    assign ret_pc_ex = pc_ex + addr_t'(1); // a call returns to the word after it

    btb u_btb (
        .clk              (clk),
        .rstn             (rstn),
        .hashed_pc        (pc_gh_hashed),
        .npc_pdc          (npc_btb),
        .hit              (btb_hit),
        .hashed_pc_update (pc_ex_gh_hashed),
        .npc_real         (npc_ex),
        .update_en        (btb_upd)
    );

    ras u_ras (
        .clk        (clk),
        .rstn       (rstn),
        .is_call_ex (kind_ex == CALL),
        .ret_pc_ex  (ret_pc_ex),
        .is_ret_ex  (kind_ex == RET),
        .ret_pc_pdc (npc_ras),
        .empty      (ras_empty)
    );

    cpht u_cpht (
        .clk              (clk),
        .rstn             (rstn),
        .hashed_pc        (pc_gh_hashed),
        .choice_pdc       (choice_btb_ras),
        .hashed_pc_update (pc_ex_gh_hashed),
        .choice_real      (choice_real),
        .update_en        (kind_ex == RET)
    );

    assign pc_seq   = pc + addr_t'(1);
    assign btb_pick = btb_hit ? npc_btb : pc_seq; // a miss falls through

    always_comb begin
        npc_pdc = pc_seq;
        if (taken_pdc) begin
            case (kind_pdc)
                DIRECT_JUMP, JUMP, CALL, INDIRECT_JUMP, OTHER_JUMP: npc_pdc = btb_pick;
                RET: npc_pdc = (choice_btb_ras && !ras_empty) ? npc_ras : btb_pick;
                default: npc_pdc = pc_seq;
            endcase
        end
    end

endmodule

/* bp_top.sv */
module bp_top (
    input  logic                clk,
    input  logic                rstn,
    // fetch
    input  npc_pkg::addr_t      pc,
    input  npc_pkg::jump_kind_e kind_pdc,
    input  logic                taken_pdc,
    output npc_pkg::addr_t      npc_pdc,
    output logic                choice_btb_ras,
    // execute
    input  npc_pkg::jump_kind_e kind_ex,
    input  npc_pkg::addr_t      pc_ex,
    input  npc_pkg::addr_t      npc_ex,
    input  logic                taken_ex,
    input  logic                choice_real,
    input  npc_pkg::idx_t       pc_ex_gh_hashed
);
    import npc_pkg::*;

    idx_t pc_gh_hashed;

    gh_hasher u_hash (
        .clk          (clk),
        .rstn         (rstn),
        .pc           (pc),
        .kind_ex      (kind_ex),
        .taken_ex     (taken_ex),
        .pc_gh_hashed (pc_gh_hashed)
    );

    npc_predictor u_npc (
        .clk             (clk),
        .rstn            (rstn),
        .pc_gh_hashed    (pc_gh_hashed),
        .pc              (pc),
        .kind_pdc        (kind_pdc),
        .taken_pdc       (taken_pdc),
        .pc_ex_gh_hashed (pc_ex_gh_hashed),
        .pc_ex           (pc_ex),
        .npc_ex          (npc_ex),
        .kind_ex         (kind_ex),
        .choice_real     (choice_real),
        .npc_pdc         (npc_pdc),
        .choice_btb_ras  (choice_btb_ras)
    );

endmodule

/* bp_asserts.sv */
module bp_checks (
    input logic                clk,
    input logic                rstn,
    input npc_pkg::addr_t      pc,
    input npc_pkg::jump_kind_e kind_pdc,
    input logic                taken_pdc,
    input npc_pkg::addr_t      npc_pdc,
    input logic                choice_btb_ras,
    input npc_pkg::jump_kind_e kind_ex
);
    timeunit 1ns;
    timeprecision 1ps;
    import npc_pkg::*;

    int   fail_cnt = 0;
    logic ret_seen; // set once the first return has updated a counter

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ret_seen <= 1'b0;
        end else if (kind_ex == RET) begin
            ret_seen <= 1'b1;
        end
    end

    not_taken_seq: assert property (@(posedge clk) disable iff (!rstn)
        !taken_pdc |-> npc_pdc == pc + addr_t'(1))
    else begin
        $error("npc_pdc is not pc+1 while taken_pdc is low");
        fail_cnt++;
    end

    not_jump_seq: assert property (@(posedge clk) disable iff (!rstn)
        kind_pdc == NOT_JUMP |-> npc_pdc == pc + addr_t'(1))
    else begin
        $error("npc_pdc is not pc+1 for a fetch that is no jump");
        fail_cnt++;
    end

    // every counter starts weakly btb and only a return can move it
    choice_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        !ret_seen |-> !choice_btb_ras)
    else begin
        $error("choice_btb_ras is set before any return update");
        fail_cnt++;
    end

endmodule

bind bp_top bp_checks u_checks (
    .clk            (clk),
    .rstn           (rstn),
    .pc             (pc),
    .kind_pdc       (kind_pdc),
    .taken_pdc      (taken_pdc),
    .npc_pdc        (npc_pdc),
    .choice_btb_ras (choice_btb_ras),
    .kind_ex        (kind_ex)
);

/* tb_bp.sv */
module tb_bp;
    timeunit 1ns;
    timeprecision 1ps;
    import npc_pkg::*;

    logic       clk;
    logic       rstn;
    addr_t      pc;
    jump_kind_e kind_pdc;
    logic       taken_pdc;
    addr_t      npc_pdc;
    logic       choice_btb_ras;
    jump_kind_e kind_ex;
    addr_t      pc_ex;
    addr_t      npc_ex;
    logic       taken_ex;
    logic       choice_real;
    idx_t       pc_ex_gh_hashed;

    // reference model of the predictor state
    idx_t       ghr_m;
    addr_t      btb_tgt_m [TABLE_LEN];
    logic       btb_val_m [TABLE_LEN];
    logic [1:0] ctr_m [TABLE_LEN];
    addr_t      stack_m [$]; // newest entry sits at the back
    int         test_no;
    int         test_errs;
    int         failed_tests;
    int         total_errs;

    bp_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #1_000_000;
        $display("timeout, the run did not end within 1 ms");
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic is_jump(jump_kind_e k);
        return k inside {DIRECT_JUMP, JUMP, CALL, RET, INDIRECT_JUMP, OTHER_JUMP};
    endfunction

    function automatic idx_t hash_of(addr_t a);
        return a[GH_WIDTH-1:0] ^ ghr_m;
    endfunction

    // random fetch pc whose hash lands on index h with the current history
    function automatic addr_t pc_at(idx_t h);
        addr_t a;
        a = addr_t'($urandom);
        a[GH_WIDTH-1:0] = h ^ ghr_m;
        return a;
    endfunction

    function automatic addr_t expected_npc();
        idx_t  h;
        addr_t seq;
        addr_t by_btb;
        h = hash_of(pc);
        seq = pc + addr_t'(1);
        by_btb = btb_val_m[h] ? btb_tgt_m[h] : seq;
        if (!taken_pdc || !is_jump(kind_pdc)) return seq;
        if (kind_pdc == RET && ctr_m[h][1] && stack_m.size() != 0) return stack_m[$];
        return by_btb;
    endfunction

    function automatic void update_model();
        idx_t h;
        h = pc_ex_gh_hashed;
        if (!is_jump(kind_ex)) return;
        ghr_m = {ghr_m[GH_WIDTH-2:0], taken_ex};
        btb_tgt_m[h] = npc_ex;
        btb_val_m[h] = 1'b1;
        if (kind_ex == CALL) begin
            if (stack_m.size() == STACK_LEN) void'(stack_m.pop_front()); // oldest is lost
            stack_m.push_back(pc_ex + addr_t'(1));
        end
        if (kind_ex == RET) begin
            if (stack_m.size() != 0) void'(stack_m.pop_back());
            if (choice_real && ctr_m[h] != 2'b11) ctr_m[h]++;
            if (!choice_real && ctr_m[h] != 2'b00) ctr_m[h]--;
        end
    endfunction

    // each call covers one clock with fetch driven first, a compare mid cycle
    // and the model update at the edge
    task automatic step(addr_t f_pc, jump_kind_e f_kind, logic f_taken);
        addr_t exp_npc;
        logic  exp_choice;
        pc = f_pc;
        kind_pdc = f_kind;
        taken_pdc = f_taken;
        @(negedge clk);
        exp_npc = expected_npc();
        exp_choice = ctr_m[hash_of(pc)][1];
        if (npc_pdc !== exp_npc) begin
            $display("ERR %0t npc_pdc got %h expected %h", $time, npc_pdc, exp_npc);
            test_errs++;
        end
        if (choice_btb_ras !== exp_choice) begin
            $display("ERR %0t choice_btb_ras got %b expected %b",
                     $time, choice_btb_ras, exp_choice);
            test_errs++;
        end
        @(posedge clk);
        update_model();
        #2;
        kind_ex = NOT_JUMP; // execute strobes last one cycle
    endtask

    task automatic execute(jump_kind_e k, addr_t p, addr_t n, logic tk, logic ch, idx_t h);
        kind_ex = k;
        pc_ex = p;
        npc_ex = n;
        taken_ex = tk;
        choice_real = ch;
        pc_ex_gh_hashed = h;
        step(addr_t'($urandom), jump_kind_e'(3'($urandom)), 1'($urandom));
    endtask

    task automatic drain_stack(idx_t rh);
        int pops;
        pops = 0;
        while (stack_m.size() != 0 && pops <= STACK_LEN) begin
            step(pc_at(rh), RET, 1'b1);
            execute(RET, addr_t'($urandom), stack_m[$], 1'b1, 1'b1, rh);
            pops++;
        end
        if (stack_m.size() != 0) begin
            $display("stack still holds %0d entries after %0d pops", stack_m.size(), pops);
            test_errs++;
        end
    endtask

    task automatic finish_test(string name);
        string verdict;
        test_no++;
        if (test_errs == 0) verdict = "ok";
        else verdict = "failed";
        $display("test %0d %s: %s, %0d mismatches", test_no, name, verdict, test_errs);
        if (test_errs != 0) failed_tests++;
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        idx_t  h;
        idx_t  rh;
        addr_t t;
        void'($urandom(32'h94dbd61f));
        rstn = 1'b0;
        pc = '0;
        kind_pdc = NOT_JUMP;
        taken_pdc = 1'b0;
        kind_ex = NOT_JUMP;
        pc_ex = '0;
        npc_ex = '0;
        taken_ex = 1'b0;
        choice_real = 1'b0;
        pc_ex_gh_hashed = '0;
        ghr_m = '0;
        for (int i = 0; i < TABLE_LEN; i++) begin
            btb_val_m[i] = 1'b0;
            ctr_m[i] = 2'b01;
        end
        test_no = 0;
        test_errs = 0;
        failed_tests = 0;
        total_errs = 0;
        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;

        for (int k = 0; k < 8; k++) step(addr_t'($urandom), jump_kind_e'(3'(k)), 1'b1);
        finish_test("empty btb");

        h = idx_t'($urandom);
        execute(JUMP, addr_t'($urandom), addr_t'($urandom), 1'b1, 1'b0, h);
        for (int k = 0; k < 8; k++) step(pc_at(h), jump_kind_e'(3'(k)), 1'b0);
        finish_test("not taken");

        h = idx_t'($urandom);
        t = addr_t'($urandom);
        execute(JUMP, addr_t'($urandom), t, 1'b1, 1'b0, h);
        step(pc_at(h), DIRECT_JUMP, 1'b1);
        step(pc_at(h), INDIRECT_JUMP, 1'b1);
        step(pc_at(h), RET, 1'b1); // counter still leans to the btb
        finish_test("btb hit");

        rh = idx_t'($urandom);
        execute(RET, addr_t'($urandom), addr_t'($urandom), 1'b1, 1'b1, rh);
        execute(RET, addr_t'($urandom), addr_t'($urandom), 1'b1, 1'b1, rh);
        execute(CALL, addr_t'($urandom), addr_t'($urandom), 1'b1, 1'b0, idx_t'($urandom));
        step(pc_at(rh), RET, 1'b1);
        finish_test("call return");

        for (int i = 0; i < 3; i++) begin
            execute(CALL, addr_t'($urandom), addr_t'($urandom), 1'b1, 1'b0, idx_t'($urandom));
        end
        drain_stack(rh);
        execute(RET, addr_t'($urandom), addr_t'($urandom), 1'b1, 1'b1, rh);
        step(pc_at(rh), RET, 1'b1);
        for (int i = 0; i < STACK_LEN + 1; i++) begin
            execute(CALL, addr_t'($urandom), addr_t'($urandom), 1'b1, 1'b0, idx_t'($urandom));
        end
        drain_stack(rh);
        step(pc_at(rh), RET, 1'b1); // the ninth push left nothing behind the newest eight
        finish_test("nested calls");

        t = addr_t'($urandom);
        execute(RET, addr_t'($urandom), t, 1'b0, 1'b0, rh);
        execute(RET, addr_t'($urandom), t, 1'b0, 1'b0, rh);
        execute(CALL, addr_t'($urandom), addr_t'($urandom), 1'b1, 1'b0, idx_t'($urandom));
        step(pc_at(rh), RET, 1'b1);
        finish_test("choice back");

        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 test_no, failed_tests, total_errs, u_dut.u_checks.fail_cnt);
        if (total_errs == 0 && failed_tests == 0 && u_dut.u_checks.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
npc_pkg.sv
gh_hasher.sv
btb.sv
ras.sv
cpht.sv
npc_predictor.sv
bp_top.sv
bp_asserts.sv
tb_bp.sv

/* Makefile */
SIM  := obj_dir/Vtb_bp
SRCS := $(shell cat files.f)

all: run

$(SIM): $(SRCS) files.f
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_bp -f files.f

run: $(SIM)
	-./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
